// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= bfs_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
verilog/bfs_csr_pkg.sv
verilog/bfs_graph_pkg.sv
verilog/graph_rd_if.sv
verilog/node_stream_if.sv
verilog/bfs_queue.sv
verilog/graph_mem.sv
verilog/node_fetch.sv
verilog/bfs_core.sv
verilog/bfs_accel_top.sv
sim/bfs_core_assert.sv
sim/bfs_tb.sv

// ==== sim/bfs_core_assert.sv ====
`default_nettype none

module bfs_core_assert (
  input logic       clk,
  input logic       rst,
  input logic       csr_valid,
  input logic       csr_rvalid,
  input logic [1:0] enq_count,
  input logic       full2,
  input logic       done,
  input logic       beat_fire,
  input logic       beat_first,
  input logic       hdr_state
);
  timeunit 1ns;
  timeprecision 1ps;

  // Response flag is the request flag one cycle late
  rvalid_follows: assert property (@(posedge clk) disable iff (rst)
    csr_valid |=> csr_rvalid)
    else $error("csr_rvalid missing after csr_valid");

  rvalid_quiet: assert property (@(posedge clk) disable iff (rst)
    !csr_valid |=> !csr_rvalid)
    else $error("csr_rvalid without a request");

  enq_legal: assert property (@(posedge clk) disable iff (rst)
    enq_count != 2'd3)
    else $error("enq_count is 3");

  // Stream is stalled instead
  no_enq_full: assert property (@(posedge clk) disable iff (rst)
    full2 |-> (enq_count == 2'd0))
    else $error("enqueue while full2 is set");

  no_enq_idle: assert property (@(posedge clk) disable iff (rst)
    done |-> (enq_count == 2'd0))
    else $error("enqueue while the core is idle");

  // Header beats carry the first flag, neighbor beats do not
  beat_first_match: assert property (@(posedge clk) disable iff (rst)
    beat_fire |-> (beat_first == hdr_state))
    else $error("beat_first does not match the core state");

endmodule

bind bfs_core bfs_core_assert u_core_assert (
  .clk        (clk),
  .rst        (rst),
  .csr_valid  (csr_valid),
  .csr_rvalid (csr_rvalid),
  .enq_count  (enq_count),
  .full2      (full2),
  .done       (done),
  .beat_fire  (beat_fire),
  .beat_first (nbeat.beat_first),
  .hdr_state  (state == HEADER)
);

`default_nettype wire

// ==== sim/bfs_tb.sv ====
`default_nettype none

module bfs_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import bfs_csr_pkg::*;
  import bfs_graph_pkg::*;

  localparam int NUM_GRAPHS   = 30;
  localparam int MAX_NODES    = 40;
  localparam int MAX_EDGES    = 60;
  localparam int MAX_DEG      = 15;
  // Header plus up to eight neighbor words
  localparam int REC_WORDS    = 9;
  localparam int SETUP_CYCLES = 500;
  localparam int GRAPH_CYCLES = 3000;

  logic       clk;
  logic       rst;
  logic       csr_valid;
  csr_addr_t  csr_addr;
  logic       csr_wen;
  csr_data_t  csr_wdata;
  logic       csr_rvalid;
  logic       csr_error;
  csr_data_t  csr_rdata;
  logic       load_valid;
  node_addr_t load_addr;
  mem_word_t  load_data;

  integer seed;
  int     num_nodes;
  int     deg [MAX_NODES];
  int     adj [MAX_NODES][MAX_DEG];
  bit     reach [MAX_NODES];

  bfs_accel_top #(.MEM_WORDS(1024), .QUEUE_DEPTH(64)) u_dut (
    .clk        (clk),
    .rst        (rst),
    .csr_valid  (csr_valid),
    .csr_addr   (csr_addr),
    .csr_wen    (csr_wen),
    .csr_wdata  (csr_wdata),
    .csr_rvalid (csr_rvalid),
    .csr_error  (csr_error),
    .csr_rdata  (csr_rdata),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic int pick_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic node_addr_t rec_addr(input int idx);
    return node_addr_t'(idx * REC_WORDS * 8);
  endfunction

  // One request, response sampled a cycle later on the falling edge
  task automatic bus_access(input csr_addr_t addr, input logic wen, input csr_data_t wdata,
                            output csr_data_t rdata, output logic err);
    @(negedge clk);
    csr_valid = 1'b1;
    csr_addr  = addr;
    csr_wen   = wen;
    csr_wdata = wdata;
    @(negedge clk);
    csr_valid = 1'b0;
    csr_wen   = 1'b0;
    if (csr_rvalid !== 1'b1) begin
      abort_run("register bus gave no response one cycle after the request");
    end
    rdata = csr_rdata;
    err   = csr_error;
  endtask

  task automatic reg_write(input csr_addr_t addr, input csr_data_t wdata);
    csr_data_t rdata;
    logic      err;
    bus_access(addr, 1'b1, wdata, rdata, err);
    check_flag("csr_error", err, 1'b0);
  endtask

  task automatic reg_read(input csr_addr_t addr, output csr_data_t rdata);
    logic err;
    bus_access(addr, 1'b0, '0, rdata, err);
    check_flag("csr_error", err, 1'b0);
  endtask

  task automatic test_readback();
    csr_addr_t addr;
    csr_data_t val;
    csr_data_t rdata;
    int        i;
    for (i = 0; i < 20; i++) begin
      addr = csr_addr_t'(int'(REG_ROOT) + pick_below(4));
      val  = csr_data_t'($random(seed));
      reg_write(addr, val);
      reg_read(addr, rdata);
      check_data("csr_rdata", rdata, val);
    end
  endtask

  task automatic test_bad_addr();
    csr_data_t rdata;
    logic      err;
    int        a;
    for (a = 6; a < 16; a++) begin
      bus_access(csr_addr_t'(a), logic'(a & 1), csr_data_t'($random(seed)), rdata, err);
      check_flag("csr_error", err, 1'b1);
    end
  endtask

  // Mostly sparse nodes, now and then a wide one
  task automatic build_graph();
    int budget;
    int i;
    int k;
    budget    = MAX_EDGES;
    num_nodes = 2 + pick_below(MAX_NODES - 1);
    for (i = 0; i < num_nodes; i++) begin
      deg[i] = (pick_below(8) == 0) ? pick_below(MAX_DEG + 1) : pick_below(3);
      if (deg[i] > budget) begin
        deg[i] = budget;
      end
      budget -= deg[i];
      for (k = 0; k < deg[i]; k++) begin
        adj[i][k] = pick_below(num_nodes);
      end
    end
  endtask

  task automatic write_word(input node_addr_t addr, input mem_word_t data);
    @(negedge clk);
    load_valid = 1'b1;
    load_addr  = addr;
    load_data  = data;
  endtask

  task automatic load_graph();
    mem_word_t word;
    int        i;
    int        w;
    for (i = 0; i < num_nodes; i++) begin
      word = '0;
      word[NCOUNT_LSB +: 4] = neigh_ct_t'(deg[i]);
      write_word(rec_addr(i), word);
      for (w = 0; w < (deg[i] + 1) / 2; w++) begin
        word = '0;
        word[31:0] = rec_addr(adj[i][2 * w]);
        if (2 * w + 1 < deg[i]) begin
          word[63:32] = rec_addr(adj[i][2 * w + 1]);
        end
        write_word(rec_addr(i) + node_addr_t'(8 * (w + 1)), word);
      end
    end
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  // Reference search over the adjacency lists
  function automatic int model_bfs(input int root_idx);
    int fifo [$];
    int n;
    int cnt;
    int i;
    int k;
    for (i = 0; i < MAX_NODES; i++) begin
      reach[i] = 1'b0;
    end
    reach[root_idx] = 1'b1;
    cnt = 1;
    fifo.push_back(root_idx);
    while (fifo.size() > 0) begin
      n = fifo.pop_front();
      for (k = 0; k < deg[n]; k++) begin
        if (!reach[adj[n][k]]) begin
          reach[adj[n][k]] = 1'b1;
          cnt++;
          fifo.push_back(adj[n][k]);
        end
      end
    end
    return cnt;
  endfunction

  task automatic run_search(input int root_idx, input int targ_idx,
                            input csr_data_t exp_visited, input logic exp_found);
    csr_data_t stat;
    csr_data_t rdata;
    reg_write(REG_ROOT, rec_addr(root_idx));
    reg_write(REG_TARG, rec_addr(targ_idx));
    reg_write(REG_STAT, '0);
    // Done drops in the cycle after the start write
    reg_read(REG_STAT, stat);
    check_flag("stat_done", stat[STAT_DONE], 1'b0);
    while (stat[STAT_DONE] !== 1'b1) begin
      reg_read(REG_STAT, stat);
    end
    check_flag("stat_overflow", stat[STAT_OVERFLOW], 1'b0);
    check_flag("stat_found", stat[STAT_FOUND], exp_found);
    reg_read(REG_VISITED, rdata);
    check_data("visited", rdata, exp_visited);
  endtask

  initial begin
    repeat (SETUP_CYCLES + NUM_GRAPHS * GRAPH_CYCLES) @(posedge clk);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    int        g;
    int        root;
    int        targ;
    csr_data_t exp_visited;
    logic      exp_found;
    seed       = 32'h37e6f877;
    rst        = 1'b1;
    csr_valid  = 1'b0;
    csr_addr   = '0;
    csr_wen    = 1'b0;
    csr_wdata  = '0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_readback();
    test_bad_addr();
    for (g = 0; g < NUM_GRAPHS; g++) begin
      build_graph();
      load_graph();
      root = pick_below(num_nodes);
      targ = (pick_below(4) == 0) ? root : pick_below(num_nodes);
      // Reachable set is filled in by the model before it is read
      exp_visited = csr_data_t'(model_bfs(root));
      exp_found   = reach[targ];
      run_search(root, targ, exp_visited, exp_found);
      // Root is marked now, so nothing is expanded again
      targ = (pick_below(2) == 0) ? root : pick_below(num_nodes);
      run_search(root, targ, '0, targ == root);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/bfs_accel_top.sv ====
`default_nettype none

module bfs_accel_top #(
  parameter int MEM_WORDS   = 1024,
  parameter int QUEUE_DEPTH = 64
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      csr_valid,
  input  bfs_csr_pkg::csr_addr_t    csr_addr,
  input  logic                      csr_wen,
  input  bfs_csr_pkg::csr_data_t    csr_wdata,
  output logic                      csr_rvalid,
  output logic                      csr_error,
  output bfs_csr_pkg::csr_data_t    csr_rdata,
  input  logic                      load_valid,
  input  bfs_graph_pkg::node_addr_t load_addr,
  input  bfs_graph_pkg::mem_word_t  load_data
);
  import bfs_graph_pkg::*;

  logic       q_clear;
  logic [1:0] enq_count;
  mem_word_t  enq_data;
  logic       full2;
  logic       q_empty;
  logic       deq_valid;
  logic       deq_ready;
  logic       deq_fire;
  node_addr_t deq_data;
  logic       fetch_idle;

  graph_rd_if    u_rd_if ();
  node_stream_if u_nbeat_if ();

  assign deq_fire = deq_valid && deq_ready;

  bfs_core u_core (
    .clk        (clk),
    .rst        (rst),
    .csr_valid  (csr_valid),
    .csr_addr   (csr_addr),
    .csr_wen    (csr_wen),
    .csr_wdata  (csr_wdata),
    .csr_rvalid (csr_rvalid),
    .csr_error  (csr_error),
    .csr_rdata  (csr_rdata),
    .q_clear    (q_clear),
    .enq_count  (enq_count),
    .enq_data   (enq_data),
    .full2      (full2),
    .q_empty    (q_empty),
    .deq_fire   (deq_fire),
    .deq_data   (deq_data),
    .fetch_idle (fetch_idle),
    .nbeat      (u_nbeat_if.dst)
  );

  bfs_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk       (clk),
    .rst       (rst),
    .clear     (q_clear),
    .enq_count (enq_count),
    .enq_data  (enq_data),
    .full2     (full2),
    .deq_valid (deq_valid),
    .deq_ready (deq_ready),
    .deq_data  (deq_data),
    .empty     (q_empty)
  );

  node_fetch #(.MEM_WORDS(MEM_WORDS)) u_fetch (
    .clk       (clk),
    .rst       (rst),
    .deq_valid (deq_valid),
    .deq_ready (deq_ready),
    .deq_data  (deq_data),
    .rd        (u_rd_if.fetch),
    .nbeat     (u_nbeat_if.src),
    .idle      (fetch_idle)
  );

  graph_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk        (clk),
    .rst        (rst),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .rd         (u_rd_if.mem)
  );

endmodule

`default_nettype wire

// ==== verilog/bfs_core.sv ====
`default_nettype none

module bfs_core (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      csr_valid,
  input  bfs_csr_pkg::csr_addr_t    csr_addr,
  input  logic                      csr_wen,
  input  bfs_csr_pkg::csr_data_t    csr_wdata,
  output logic                      csr_rvalid,
  output logic                      csr_error,
  output bfs_csr_pkg::csr_data_t    csr_rdata,
  output logic                      q_clear,
  output logic [1:0]                enq_count,
  output bfs_graph_pkg::mem_word_t  enq_data,
  input  logic                      full2,
  input  logic                      q_empty,
  input  logic                      deq_fire,
  input  bfs_graph_pkg::node_addr_t deq_data,
  input  logic                      fetch_idle,
  node_stream_if.dst                nbeat
);
  import bfs_csr_pkg::*;
  import bfs_graph_pkg::*;

  typedef enum logic [1:0] {IDLE, INIT, HEADER, ADD_NEIGHS} state_t;

  state_t    state;
  csr_data_t root;
  csr_data_t targ;
  csr_data_t qbase;
  csr_data_t qsize;
  csr_data_t visited;
  csr_data_t stat_word;
  logic      found;
  logic      done;
  logic      overflow;
  neigh_ct_t neigh_ct;
  neigh_ct_t hdr_ct;
  logic      csr_wr;
  logic      start;
  logic      beat_fire;
  logic      hdr_marked;
  logic      search_end;

  assign csr_wr     = csr_valid && csr_wen;
  assign start      = csr_wr && (csr_addr == REG_STAT) && (state == IDLE);
  assign q_clear    = start;
  assign beat_fire  = nbeat.beat_valid && nbeat.beat_ready;
  assign hdr_marked = nbeat.beat_data[MARK_BIT];
  assign hdr_ct     = nbeat.beat_data[NCOUNT_LSB +: 4];
  // Nothing queued, nothing being fetched, nothing waiting on the stream
  assign search_end = q_empty && fetch_idle && !nbeat.beat_valid;

  always_comb begin
    nbeat.beat_ready = 1'b0;
    enq_count        = 2'd0;
    enq_data         = mem_word_t'(root);
    case (state)
      INIT: enq_count = 2'd1;
      HEADER: nbeat.beat_ready = 1'b1;
      ADD_NEIGHS: begin
        // Stall the stream rather than drop neighbors
        nbeat.beat_ready = !full2;
        enq_data         = nbeat.beat_data;
        if (nbeat.beat_valid && !full2) begin
          enq_count = (neigh_ct == 4'd1) ? 2'd1 : 2'd2;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      found    <= 1'b0;
      overflow <= 1'b0;
      done     <= 1'b1;
      visited  <= '0;
      neigh_ct <= '0;
    end else begin
      if ((enq_count != 2'd0) && full2) begin
        overflow <= 1'b1;
      end
      if ((state != IDLE) && deq_fire && (deq_data == targ)) begin
        found <= 1'b1;
      end
      case (state)
        IDLE: begin
          if (start) begin
            state    <= INIT;
            found    <= 1'b0;
            overflow <= 1'b0;
            visited  <= '0;
            done     <= 1'b0;
          end
        end
        INIT: state <= HEADER;
        HEADER: begin
          if (beat_fire) begin
            if (!hdr_marked) begin
              visited <= visited + 1'b1;
            end
            if (!hdr_marked && (hdr_ct != '0)) begin
              neigh_ct <= hdr_ct;
              state    <= ADD_NEIGHS;
            end
          end else if (search_end) begin
            done  <= 1'b1;
            state <= IDLE;
          end
        end
        ADD_NEIGHS: begin
          if (beat_fire) begin
            if (neigh_ct <= 4'd2) begin
              state <= HEADER;
            end else begin
              neigh_ct <= neigh_ct - 4'd2;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    stat_word                = '0;
    stat_word[STAT_FOUND]    = found;
    stat_word[STAT_DONE]     = done;
    stat_word[STAT_OVERFLOW] = overflow;
  end

  // Register bus response, one cycle after the request
  always_ff @(posedge clk) begin
    if (rst) begin
      csr_rvalid <= 1'b0;
      csr_error  <= 1'b0;
    end else begin
      csr_rvalid <= csr_valid;
      csr_error  <= csr_valid && (csr_addr > REG_VISITED);
    end
  end

  always_ff @(posedge clk) begin
    if (csr_valid) begin
      case (csr_addr)
        REG_STAT:    csr_rdata <= stat_word;
        REG_ROOT:    csr_rdata <= root;
        REG_TARG:    csr_rdata <= targ;
        REG_QBASE:   csr_rdata <= qbase;
        REG_QSIZE:   csr_rdata <= qsize;
        REG_VISITED: csr_rdata <= visited;
        default:     csr_rdata <= '0;
      endcase
    end
    // Queue base and size are readback only
    if (csr_wr) begin
      case (csr_addr)
        REG_ROOT:  root  <= csr_wdata;
        REG_TARG:  targ  <= csr_wdata;
        REG_QBASE: qbase <= csr_wdata;
        REG_QSIZE: qsize <= csr_wdata;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bfs_csr_pkg.sv ====
`default_nettype none

package bfs_csr_pkg;

  // Register bus widths
  localparam int CSR_ADDR_W = 4;
  localparam int CSR_DATA_W = 32;

  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CSR_DATA_W-1:0] csr_data_t;

  // Register map
  localparam csr_addr_t REG_STAT    = 4'd0;
  localparam csr_addr_t REG_ROOT    = 4'd1;
  localparam csr_addr_t REG_TARG    = 4'd2;
  localparam csr_addr_t REG_QBASE   = 4'd3;
  localparam csr_addr_t REG_QSIZE   = 4'd4;
  localparam csr_addr_t REG_VISITED = 4'd5;

  // Status register bits
  localparam int STAT_FOUND    = 0;
  localparam int STAT_DONE     = 1;
  localparam int STAT_OVERFLOW = 2;

endpackage

`default_nettype wire

// ==== verilog/bfs_graph_pkg.sv ====
`default_nettype none

package bfs_graph_pkg;

  // Byte address of a node record or word
  typedef logic [31:0] node_addr_t;

  // One memory word, either a header or two neighbor addresses
  typedef logic [63:0] mem_word_t;

  // Neighbor count held in the header
  typedef logic [3:0] neigh_ct_t;

  // Header fields
  localparam int MARK_BIT   = 0;
  localparam int NCOUNT_LSB = 32;

endpackage

`default_nettype wire

// ==== verilog/bfs_queue.sv ====
`default_nettype none

module bfs_queue #(
  parameter int QUEUE_DEPTH = 64
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       clear,
  input  logic [1:0]                 enq_count,
  input  bfs_graph_pkg::mem_word_t   enq_data,
  output logic                       full2,
  output logic                       deq_valid,
  input  logic                       deq_ready,
  output bfs_graph_pkg::node_addr_t  deq_data,
  output logic                       empty
);
  import bfs_graph_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  node_addr_t       buf_q [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] wr_ptr_nx;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] cnt;
  logic             enq_ok;
  logic             deq_fire;
  logic [1:0]       n_in;

  // Entries are dropped rather than written when fewer than two slots are free
  assign enq_ok    = (enq_count != 2'd0) && !full2;
  assign n_in      = !enq_ok ? 2'd0 : (enq_count[1] ? 2'd2 : 2'd1);
  assign wr_ptr_nx = wr_ptr + 1'b1;
  assign deq_fire  = deq_valid && deq_ready;

  assign empty     = (cnt == '0);
  assign full2     = (cnt >= CNT_W'(QUEUE_DEPTH - 1));
  assign deq_valid = !empty;
  assign deq_data  = buf_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(n_in);
      if (deq_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      cnt <= cnt + CNT_W'(n_in) - CNT_W'(deq_fire);
    end
  end

  // Low half goes in first, high half follows in the next slot
  always_ff @(posedge clk) begin
    if (enq_ok) begin
      buf_q[wr_ptr] <= enq_data[31:0];
      if (enq_count[1]) begin
        buf_q[wr_ptr_nx] <= enq_data[63:32];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/graph_mem.sv ====
`default_nettype none

module graph_mem #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load_valid,
  input  bfs_graph_pkg::node_addr_t load_addr,
  input  bfs_graph_pkg::mem_word_t  load_data,
  graph_rd_if.mem                   rd
);
  import bfs_graph_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  mem_word_t        mem [MEM_WORDS];
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] ld_idx;
  logic             rd_fire;

  // Loading owns the array, reads wait
  assign rd.req_ready = !load_valid;
  assign rd_fire      = rd.req_valid && rd.req_ready;
  assign rd_idx       = rd.req_addr[IDX_W+2:3];
  assign ld_idx       = load_addr[IDX_W+2:3];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd.rsp_valid <= 1'b0;
    end else begin
      rd.rsp_valid <= rd_fire;
    end
  end

  // Marked read returns the old word and sets the mark in storage
  always_ff @(posedge clk) begin
    if (load_valid) begin
      mem[ld_idx] <= load_data;
    end else if (rd_fire && rd.req_mark) begin
      mem[rd_idx][MARK_BIT] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rd.rsp_data <= mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/graph_rd_if.sv ====
`default_nettype none

interface graph_rd_if;
  import bfs_graph_pkg::*;

  // Request side, one read in flight at most
  logic       req_valid;
  logic       req_ready;
  node_addr_t req_addr;
  logic       req_mark;

  // Response arrives one cycle after the request transfer
  logic      rsp_valid;
  mem_word_t rsp_data;

  modport fetch (
    output req_valid, req_addr, req_mark,
    input  req_ready, rsp_valid, rsp_data
  );

  modport mem (
    input  req_valid, req_addr, req_mark,
    output req_ready, rsp_valid, rsp_data
  );

endinterface

`default_nettype wire

// ==== verilog/node_fetch.sv ====
`default_nettype none

module node_fetch #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      deq_valid,
  output logic                      deq_ready,
  input  bfs_graph_pkg::node_addr_t deq_data,
  graph_rd_if.fetch                 rd,
  node_stream_if.src                nbeat,
  output logic                      idle
);
  import bfs_graph_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HDR,
    S_HDR_WAIT,
    S_WORD,
    S_WORD_WAIT
  } state_t;

  state_t           state;
  logic [IDX_W-1:0] word_idx;
  logic [3:0]       words_left;
  neigh_ct_t        hdr_ct;
  logic             beat_fire;

  assign idle      = (state == S_IDLE);
  assign deq_ready = (state == S_IDLE);
  assign beat_fire = nbeat.beat_valid && nbeat.beat_ready;
  assign hdr_ct    = nbeat.beat_data[NCOUNT_LSB +: 4];

  // Header read sets the mark, neighbor reads do not
  assign rd.req_valid = (state == S_HDR) || (state == S_WORD);
  assign rd.req_mark  = (state == S_HDR);
  assign rd.req_addr  = node_addr_t'({word_idx, 3'b000});

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= S_IDLE;
      nbeat.beat_valid <= 1'b0;
      word_idx         <= '0;
      words_left       <= '0;
    end else begin
      if (rd.rsp_valid) begin
        nbeat.beat_valid <= 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (deq_valid) begin
            word_idx <= deq_data[IDX_W+2:3];
            state    <= S_HDR;
          end
        end
        S_HDR: begin
          if (rd.req_ready) begin
            state <= S_HDR_WAIT;
          end
        end
        S_HDR_WAIT: begin
          if (beat_fire) begin
            nbeat.beat_valid <= 1'b0;
            word_idx         <= word_idx + 1'b1;
            // Two neighbors per word, rounded up
            words_left <= {1'b0, hdr_ct[3:1]} + {3'b000, hdr_ct[0]};
            if (nbeat.beat_data[MARK_BIT] || (hdr_ct == '0)) begin
              state <= S_IDLE;
            end else begin
              state <= S_WORD;
            end
          end
        end
        S_WORD: begin
          if (rd.req_ready) begin
            state <= S_WORD_WAIT;
          end
        end
        S_WORD_WAIT: begin
          if (beat_fire) begin
            nbeat.beat_valid <= 1'b0;
            word_idx         <= word_idx + 1'b1;
            words_left       <= words_left - 4'd1;
            state            <= (words_left == 4'd1) ? S_IDLE : S_WORD;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Response lands in the beat register, it cannot be stalled
  always_ff @(posedge clk) begin
    if (rd.rsp_valid) begin
      nbeat.beat_data  <= rd.rsp_data;
      nbeat.beat_first <= (state == S_HDR_WAIT);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/node_stream_if.sv ====
`default_nettype none

interface node_stream_if;
  import bfs_graph_pkg::*;

  logic      beat_valid;
  logic      beat_ready;
  mem_word_t beat_data;
  // Set on the header word of a node record
  logic      beat_first;

  modport src (output beat_valid, beat_data, beat_first, input beat_ready);
  modport dst (input beat_valid, beat_data, beat_first, output beat_ready);

endinterface

`default_nettype wire
